// File: all.f
+incdir+.
isaPkg.sv
pipePkg.sv
regFile.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
coreTop.sv
coreTb.sv

// File: Bender.yml
package:
  name: integer_core

sources:
  - files:
      - isaPkg.sv
      - pipePkg.sv
      - regFile.sv
      - decodeStage.sv
      - executeStage.sv
      - writebackStage.sv
      - coreTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - coreTb.sv

// File: tbModel.svh
// Architectural model of the core, included inside the testbench module.
// Assumes a taken branch squashes exactly the next word and HALT ends the stream.
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0]     modelRegs [8];
pipePkg::retireT expRetire [$];
logic [15:0]     expTarget [$];

// Fetch hands over the incremented PC, two bytes per slot
function automatic logic [15:0] slotPc2(int slot);
    return 16'(2 * (slot + 1));
endfunction

function automatic logic [15:0] signExt(logic [15:0] v, int bits);
    logic signed [15:0] t;
    t = $signed(v << (16 - bits));
    return t >>> (16 - bits);
endfunction

task automatic stepModel(
    input  logic [15:0]     word,
    input  logic [15:0]     pc2Val,
    output pipePkg::retireT rec,
    output logic            taken,
    output logic [15:0]     target
);
    logic [15:0] a;
    logic [15:0] b;
    a      = modelRegs[word[10:8]];
    b      = modelRegs[word[7:5]];
    rec    = '0;
    taken  = 1'b0;
    target = '0;
    rec.valid = 1'b1;
    case (word[15:11])
        isaPkg::opHalt: rec.halt = 1'b1;
        isaPkg::opNop: begin
        end
        isaPkg::opAddi: begin
            rec.wrEn   = 1'b1;
            rec.wrAddr = word[7:5];
            rec.wrData = a + signExt(word, 5);
        end
        isaPkg::opAndni: begin
            rec.wrEn   = 1'b1;
            rec.wrAddr = word[7:5];
            rec.wrData = a & ~{11'b0, word[4:0]};
        end
        isaPkg::opLbi: begin
            rec.wrEn   = 1'b1;
            rec.wrAddr = word[10:8];
            rec.wrData = signExt(word, 8);
        end
        isaPkg::opBeqz: begin
            taken  = (a == 16'h0000);
            target = pc2Val + signExt(word, 8);
        end
        isaPkg::opBnez: begin
            taken  = (a != 16'h0000);
            target = pc2Val + signExt(word, 8);
        end
        isaPkg::opJ: begin
            taken  = 1'b1;
            target = pc2Val + signExt(word, 11);
        end
        isaPkg::opRtype: begin
            rec.wrEn   = 1'b1;
            rec.wrAddr = word[4:2];
            case (word[1:0])
                isaPkg::fnAdd: rec.wrData = a + b;
                isaPkg::fnSub: rec.wrData = a - b;
                isaPkg::fnXor: rec.wrData = a ^ b;
                default:       rec.wrData = a & ~b;
            endcase
        end
        default: rec.illegal = 1'b1;
    endcase
    if (rec.wrEn) begin
        modelRegs[rec.wrAddr] = rec.wrData;
    end
endtask

// Builds the expected retire and redirect queues for the whole stream
task automatic runModel(input logic [15:0] words [$]);
    pipePkg::retireT rec;
    logic            taken;
    logic [15:0]     target;
    logic            squash;
    squash = 1'b0;
    foreach (modelRegs[r]) begin
        modelRegs[r] = '0;
    end
    expRetire.delete();
    expTarget.delete();
    for (int i = 0; i < words.size(); i++) begin
        if (squash) begin
            squash = 1'b0;
            continue;
        end
        stepModel(words[i], slotPc2(i), rec, taken, target);
        expRetire.push_back(rec);
        if (taken) begin
            expTarget.push_back(target);
            squash = 1'b1;
        end
        if (rec.halt) begin
            break;
        end
    end
endtask

`endif

// File: coreTb.sv
// Random program test of coreTop. Fetch is a straight stream of words,
// so branch targets are checked but never followed.
`timescale 1ns/10ps

module coreTb;

    localparam int progLen        = 400;
    localparam int tailLen        = 6;
    localparam int streamLen      = progLen + 1 + tailLen;
    localparam int clkPeriod      = 100;
    localparam int watchdogCycles = streamLen + 20;

    logic              clk;
    logic              rst;
    logic              instrValid;
    logic [15:0]       instr;
    logic [15:0]       pc2;
    pipePkg::redirectT redirect;
    pipePkg::retireT   retire;
    logic              halted;

    logic [31:0] lfsrState    = 32'hd549;
    logic [15:0] stream [$];
    int          errorCount   = 0;
    int          retiredCount = 0;
    logic        haltSeen     = 1'b0;

    `include "tbModel.svh"

    coreTop u_coreTop (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc2        (pc2),
        .redirect   (redirect),
        .retire     (retire),
        .halted     (halted)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v         = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic isLegalOp(logic [4:0] op);
        return op inside {isaPkg::opHalt, isaPkg::opNop, isaPkg::opAddi, isaPkg::opAndni,
                          isaPkg::opLbi, isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opJ,
                          isaPkg::opRtype};
    endfunction

    function automatic logic isBranchOp(logic [4:0] op);
        return op inside {isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opJ};
    endfunction

    function automatic logic [15:0] randomInstr();
        logic [4:0] op;
        logic [3:0] pick;
        // Roughly one word in thirty carries an unused opcode
        if (takeBits(5) == 0) begin
            op = 5'(takeBits(5));
            while (isLegalOp(op)) begin
                op = 5'(takeBits(5));
            end
        end else begin
            pick = 4'(takeBits(4));
            case (pick)
                0, 1, 2, 15: op = isaPkg::opAddi;
                3, 4:        op = isaPkg::opAndni;
                5, 6:        op = isaPkg::opLbi;
                7, 8, 9, 10: op = isaPkg::opRtype;
                11:          op = isaPkg::opBeqz;
                12:          op = isaPkg::opBnez;
                13:          op = isaPkg::opJ;
                default:     op = isaPkg::opNop;
            endcase
        end
        return {op, 11'(takeBits(11))};
    endfunction

    task automatic generateProgram();
        logic [15:0] w;
        stream.delete();
        for (int i = 0; i < progLen; i++) begin
            w = randomInstr();
            // Keeps HALT out of a branch shadow
            if ((i == progLen - 1) && isBranchOp(w[15:11])) begin
                w = {isaPkg::opNop, 11'b0};
            end
            stream.push_back(w);
        end
        stream.push_back({isaPkg::opHalt, 11'b0});
        repeat (tailLen) stream.push_back({isaPkg::opNop, 11'b0});
    endtask

    task automatic reportFailure(string what);
        errorCount++;
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkIdle();
        assert (retire.valid === 1'b0)
            else reportFailure($sformatf("FAILED retire.valid: got %h expected 0", retire.valid));
        assert (redirect.valid === 1'b0)
            else reportFailure($sformatf("FAILED redirect.valid: got %h expected 0",
                                         redirect.valid));
        assert (halted === 1'b0)
            else reportFailure($sformatf("FAILED halted: got %h expected 0", halted));
    endtask

    task automatic checkCycle();
        pipePkg::retireT exp;
        logic [15:0]     tgt;
        if (redirect.valid === 1'b1) begin
            assert (expTarget.size() > 0)
                else reportFailure("redirect asserted although no taken branch was expected");
            tgt = expTarget.pop_front();
            assert (redirect.target === tgt)
                else reportFailure($sformatf("FAILED redirect.target: got %h expected %h",
                                             redirect.target, tgt));
        end else begin
            assert (redirect.valid === 1'b0)
                else reportFailure($sformatf("FAILED redirect.valid: got %h expected 0",
                                             redirect.valid));
        end
        assert (halted === haltSeen)
            else reportFailure($sformatf("FAILED halted: got %h expected %h", halted, haltSeen));
        if (retire.valid === 1'b1) begin
            assert (expRetire.size() > 0)
                else reportFailure("an instruction retired that should not have retired");
            exp = expRetire.pop_front();
            assert (retire.halt === exp.halt)
                else reportFailure($sformatf("FAILED retire.halt: got %h expected %h",
                                             retire.halt, exp.halt));
            assert (retire.illegal === exp.illegal)
                else reportFailure($sformatf("FAILED retire.illegal: got %h expected %h",
                                             retire.illegal, exp.illegal));
            assert (retire.wrEn === exp.wrEn)
                else reportFailure($sformatf("FAILED retire.wrEn: got %h expected %h",
                                             retire.wrEn, exp.wrEn));
            if (exp.wrEn) begin
                assert (retire.wrAddr === exp.wrAddr)
                    else reportFailure($sformatf("FAILED retire.wrAddr: got %h expected %h",
                                                 retire.wrAddr, exp.wrAddr));
                assert (retire.wrData === exp.wrData)
                    else reportFailure($sformatf("FAILED retire.wrData: got %h expected %h",
                                                 retire.wrData, exp.wrData));
            end
            retiredCount++;
            haltSeen = haltSeen | exp.halt;
        end else begin
            assert (retire.valid === 1'b0)
                else reportFailure($sformatf("FAILED retire.valid: got %h expected 0",
                                             retire.valid));
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = {isaPkg::opNop, 11'b0};
        pc2        = '0;
        generateProgram();
        runModel(stream);

        repeat (4) begin
            @(negedge clk);
            checkIdle();
        end
        rst = 1'b0;

        // Outputs depend only on pipeline registers, so checking before driving is safe
        for (int slot = 0; slot < streamLen; slot++) begin
            instrValid = 1'b1;
            instr      = stream[slot];
            pc2        = slotPc2(slot);
            @(negedge clk);
            checkCycle();
        end
        instrValid = 1'b0;
        repeat (2) begin
            @(negedge clk);
            checkCycle();
        end

        assert (expRetire.size() == 0)
            else reportFailure($sformatf("%0d expected retirements never appeared",
                                         expRetire.size()));
        assert (expTarget.size() == 0)
            else reportFailure($sformatf("%0d expected redirects never appeared",
                                         expTarget.size()));
        assert (haltSeen)
            else reportFailure("HALT never retired");
        $display("Retired %0d instructions", retiredCount);
        if (errorCount == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "checks failed");
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        reportFailure($sformatf("run did not finish within %0d cycles", watchdogCycles));
    end

endmodule

// File: coreTop.sv
// Three-stage integer core. Fetch sits outside and supplies one word per cycle.
// The core never stalls, so every valid word on the inputs is accepted.
`timescale 1ns/10ps

module coreTop (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instrValid,
    input  logic [isaPkg::dataW-1:0]  instr,
    input  logic [isaPkg::dataW-1:0]  pc2,
    output pipePkg::redirectT         redirect,
    output pipePkg::retireT           retire,
    output logic                      halted
);

    logic [isaPkg::regAddrW-1:0] rdAddrA;
    logic [isaPkg::regAddrW-1:0] rdAddrB;
    logic [isaPkg::dataW-1:0]    rdDataA;
    logic [isaPkg::dataW-1:0]    rdDataB;
    pipePkg::idExT               idEx;
    pipePkg::exWbT               exWb;
    pipePkg::rfWriteT            rfWrite;

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .write   (rfWrite)
    );

    // Redirect doubles as the squash for the word in decode
    decodeStage u_decodeStage (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc2        (pc2),
        .flush      (redirect.valid),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .idEx       (idEx)
    );

    executeStage u_executeStage (
        .clk      (clk),
        .rst      (rst),
        .idEx     (idEx),
        .fwd      (rfWrite),
        .redirect (redirect),
        .exWb     (exWb)
    );

    writebackStage u_writebackStage (
        .clk     (clk),
        .rst     (rst),
        .exWb    (exWb),
        .rfWrite (rfWrite),
        .retire  (retire),
        .halted  (halted)
    );

endmodule

// File: writebackStage.sv
// Writeback stage. Retire record and register write are combinational from exWb.
// Once HALT retires nothing else retires or writes until reset.
`timescale 1ns/10ps

module writebackStage (
    input  logic               clk,
    input  logic               rst,
    input  pipePkg::exWbT      exWb,
    output pipePkg::rfWriteT   rfWrite,
    output pipePkg::retireT    retire,
    output logic               halted
);

    logic live;

    assign live = exWb.valid && !halted;

    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (live && exWb.halt) begin
            halted <= 1'b1;
        end
    end

    assign rfWrite.en   = live && exWb.regWrite;
    assign rfWrite.addr = exWb.wrAddr;
    assign rfWrite.data = exWb.result;

    always_comb begin
        retire.valid   = live;
        retire.wrEn    = live && exWb.regWrite;
        retire.wrAddr  = exWb.wrAddr;
        retire.wrData  = exWb.result;
        retire.halt    = exWb.halt;
        retire.illegal = exWb.illegal;
    end

    // Flagged and halting instructions leave the registers alone
    flaggedNoWrite: assert property (
        @(posedge clk) disable iff (rst)
        exWb.valid && (exWb.illegal || exWb.halt) |-> !exWb.regWrite
    ) else $error("illegal or halting instruction carries a register write");

endmodule

// File: executeStage.sv
// Execute stage. Branches resolve here and redirect in the same cycle.
// Only writeback is forwarded. Older results come through the regFile bypass.
`timescale 1ns/10ps

module executeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  pipePkg::idExT        idEx,
    input  pipePkg::rfWriteT     fwd,
    output pipePkg::redirectT    redirect,
    output pipePkg::exWbT        exWb
);

    logic [isaPkg::dataW-1:0] rsOp;
    logic [isaPkg::dataW-1:0] rtOp;
    logic [isaPkg::dataW-1:0] opB;
    logic [isaPkg::dataW-1:0] aluResult;
    logic                     taken;
    pipePkg::exWbT            exWbNext;

    // Writeback result overrides the value read in decode
    assign rsOp = (fwd.en && (fwd.addr == idEx.rsAddr)) ? fwd.data : idEx.rsVal;
    assign rtOp = (fwd.en && (fwd.addr == idEx.rtAddr)) ? fwd.data : idEx.rtVal;
    assign opB  = idEx.ctrl.aluSrcImm ? idEx.imm : rtOp;

    always_comb begin
        case (idEx.ctrl.aluOp)
            isaPkg::aluAdd:   aluResult = rsOp + opB;
            isaPkg::aluSub:   aluResult = rsOp - opB;
            isaPkg::aluXor:   aluResult = rsOp ^ opB;
            isaPkg::aluAndn:  aluResult = rsOp & ~opB;
            isaPkg::aluPassB: aluResult = opB;
            default:          aluResult = rsOp + opB;
        endcase
    end

    // Branch condition on rs
    always_comb begin
        case (idEx.ctrl.branchKind)
            isaPkg::brEqz:    taken = (rsOp == '0);
            isaPkg::brNez:    taken = (rsOp != '0);
            isaPkg::brAlways: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect.valid  = idEx.valid && taken;
    assign redirect.target = idEx.pc2 + idEx.imm;

    always_comb begin
        exWbNext.valid    = idEx.valid;
        exWbNext.result   = aluResult;
        exWbNext.wrAddr   = idEx.wrAddr;
        exWbNext.regWrite = idEx.ctrl.regWrite;
        exWbNext.halt     = idEx.ctrl.halt;
        exWbNext.illegal  = idEx.ctrl.illegal;
    end

    always_ff @(posedge clk) begin
        exWb <= exWbNext;
        if (rst) begin
            exWb.valid <= 1'b0;
        end
    end

    // The word behind a taken branch reaches execute as a bubble
    takenLeavesBubble: assert property (
        @(posedge clk) disable iff (rst)
        redirect.valid |=> !idEx.valid
    ) else $error("instruction after a taken branch was not squashed");

endmodule

// File: decodeStage.sv
// Decode stage and the decode/execute register. Decodes every cycle without stalls.
// A flush from execute turns the instruction on the inputs into a bubble.
`timescale 1ns/10ps

module decodeStage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instrValid,
    input  logic [isaPkg::dataW-1:0]     instr,
    input  logic [isaPkg::dataW-1:0]     pc2,
    input  logic                         flush,
    output logic [isaPkg::regAddrW-1:0]  rdAddrA,
    output logic [isaPkg::regAddrW-1:0]  rdAddrB,
    input  logic [isaPkg::dataW-1:0]     rdDataA,
    input  logic [isaPkg::dataW-1:0]     rdDataB,
    output pipePkg::idExT                idEx
);

    isaPkg::ctrlT                ctrl;
    isaPkg::immKindT             immKind;
    isaPkg::destSelT             destSel;
    logic [isaPkg::dataW-1:0]    imm;
    logic [isaPkg::regAddrW-1:0] wrAddr;
    pipePkg::idExT               idExNext;

    // Rs and rt are always read, used or not
    assign rdAddrA = instr[isaPkg::rsHi:isaPkg::rsLo];
    assign rdAddrB = instr[isaPkg::rtHi:isaPkg::rtLo];

    always_comb begin
        ctrl.aluOp      = isaPkg::aluAdd;
        ctrl.aluSrcImm  = 1'b0;
        ctrl.branchKind = isaPkg::brNone;
        ctrl.regWrite   = 1'b0;
        ctrl.halt       = 1'b0;
        ctrl.illegal    = 1'b0;
        immKind         = isaPkg::imm5S;
        destSel         = isaPkg::dstRt;

        case (isaPkg::opcodeT'(instr[isaPkg::opHi:isaPkg::opLo]))
            isaPkg::opHalt: begin
                ctrl.halt = 1'b1;
            end
            isaPkg::opNop: begin
            end
            isaPkg::opAddi: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            isaPkg::opAndni: begin
                ctrl.aluOp     = isaPkg::aluAndn;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                immKind        = isaPkg::imm5U;
            end
            isaPkg::opLbi: begin
                ctrl.aluOp     = isaPkg::aluPassB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                immKind        = isaPkg::imm8S;
                destSel        = isaPkg::dstRs;
            end
            isaPkg::opBeqz: begin
                ctrl.branchKind = isaPkg::brEqz;
                immKind         = isaPkg::imm8S;
            end
            isaPkg::opBnez: begin
                ctrl.branchKind = isaPkg::brNez;
                immKind         = isaPkg::imm8S;
            end
            isaPkg::opJ: begin
                ctrl.branchKind = isaPkg::brAlways;
                immKind         = isaPkg::imm11S;
            end
            isaPkg::opRtype: begin
                ctrl.regWrite = 1'b1;
                destSel       = isaPkg::dstRd;
                case (isaPkg::functT'(instr[isaPkg::fnHi:isaPkg::fnLo]))
                    isaPkg::fnAdd:  ctrl.aluOp = isaPkg::aluAdd;
                    isaPkg::fnSub:  ctrl.aluOp = isaPkg::aluSub;
                    isaPkg::fnXor:  ctrl.aluOp = isaPkg::aluXor;
                    isaPkg::fnAndn: ctrl.aluOp = isaPkg::aluAndn;
                endcase
            end
            default: begin
                // Retires as a flagged no-op
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (immKind)
            isaPkg::imm5S:  imm = {{(isaPkg::dataW-5){instr[4]}}, instr[4:0]};
            isaPkg::imm5U:  imm = {{(isaPkg::dataW-5){1'b0}}, instr[4:0]};
            isaPkg::imm8S:  imm = {{(isaPkg::dataW-8){instr[7]}}, instr[7:0]};
            default:        imm = {{(isaPkg::dataW-11){instr[10]}}, instr[10:0]};
        endcase
    end

    always_comb begin
        case (destSel)
            isaPkg::dstRd: wrAddr = instr[isaPkg::rdHi:isaPkg::rdLo];
            isaPkg::dstRs: wrAddr = instr[isaPkg::rsHi:isaPkg::rsLo];
            default:       wrAddr = instr[isaPkg::rtHi:isaPkg::rtLo];
        endcase
    end

    always_comb begin
        idExNext.valid  = instrValid && !flush;
        idExNext.pc2    = pc2;
        idExNext.rsVal  = rdDataA;
        idExNext.rtVal  = rdDataB;
        idExNext.rsAddr = rdAddrA;
        idExNext.rtAddr = rdAddrB;
        idExNext.imm    = imm;
        idExNext.wrAddr = wrAddr;
        idExNext.ctrl   = ctrl;
    end

    // Payload loads every cycle, only valid is reset
    always_ff @(posedge clk) begin
        idEx <= idExNext;
        if (rst) begin
            idEx.valid <= 1'b0;
        end
    end

endmodule

// File: regFile.sv
// Eight 16-bit registers, all cleared by reset, two async read ports.
// A read of the register being written returns the new data in the same cycle.
`timescale 1ns/10ps

module regFile (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [isaPkg::regAddrW-1:0]  rdAddrA,
    input  logic [isaPkg::regAddrW-1:0]  rdAddrB,
    output logic [isaPkg::dataW-1:0]     rdDataA,
    output logic [isaPkg::dataW-1:0]     rdDataB,
    input  pipePkg::rfWriteT             write
);

    logic [isaPkg::dataW-1:0] regs [isaPkg::regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isaPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (write.en) begin
            regs[write.addr] <= write.data;
        end
    end

    // Write-through bypass on both ports
    always_comb begin
        if (write.en && (write.addr == rdAddrA)) begin
            rdDataA = write.data;
        end else begin
            rdDataA = regs[rdAddrA];
        end
    end

    always_comb begin
        if (write.en && (write.addr == rdAddrB)) begin
            rdDataB = write.data;
        end else begin
            rdDataB = regs[rdAddrB];
        end
    end

    // An X here would be bypassed into decode and forwarded into execute
    writeDataKnown: assert property (
        @(posedge clk) disable iff (rst)
        write.en |-> !$isunknown({write.addr, write.data})
    ) else $error("regFile write with unknown addr or data");

endmodule

// File: pipePkg.sv
// Payloads that travel between the pipeline stages and out of the core.
// Every record carries its own valid bit. There is no ready signal.
package pipePkg;

    // Decode to execute
    typedef struct packed {
        logic                         valid;
        logic [isaPkg::dataW-1:0]     pc2;
        logic [isaPkg::dataW-1:0]     rsVal;
        logic [isaPkg::dataW-1:0]     rtVal;
        logic [isaPkg::regAddrW-1:0]  rsAddr;
        logic [isaPkg::regAddrW-1:0]  rtAddr;
        logic [isaPkg::dataW-1:0]     imm;
        logic [isaPkg::regAddrW-1:0]  wrAddr;
        isaPkg::ctrlT                 ctrl;
    } idExT;

    // Execute to writeback
    typedef struct packed {
        logic                         valid;
        logic [isaPkg::dataW-1:0]     result;
        logic [isaPkg::regAddrW-1:0]  wrAddr;
        logic                         regWrite;
        logic                         halt;
        logic                         illegal;
    } exWbT;

    // Taken branch or jump, back toward fetch
    typedef struct packed {
        logic                         valid;
        logic [isaPkg::dataW-1:0]     target;
    } redirectT;

    typedef struct packed {
        logic                         valid;
        logic                         wrEn;
        logic [isaPkg::regAddrW-1:0]  wrAddr;
        logic [isaPkg::dataW-1:0]     wrData;
        logic                         halt;
        logic                         illegal;
    } retireT;

    typedef struct packed {
        logic                         en;
        logic [isaPkg::regAddrW-1:0]  addr;
        logic [isaPkg::dataW-1:0]     data;
    } rfWriteT;

endpackage

// File: isaPkg.sv
// Instruction set of the 16-bit core. Opcode values follow the WISC encoding.
// Only the opcodes that this integer core executes are listed here.
package isaPkg;

    localparam int dataW    = 16;
    localparam int regCount = 8;
    localparam int regAddrW = 3;
    localparam int opcodeW  = 5;
    localparam int functW   = 2;

    // Instruction field positions
    localparam int opHi = 15;
    localparam int opLo = 11;
    localparam int rsHi = 10;
    localparam int rsLo = 8;
    localparam int rtHi = 7;
    localparam int rtLo = 5;
    localparam int rdHi = 4;
    localparam int rdLo = 2;
    localparam int fnHi = 1;
    localparam int fnLo = 0;

    typedef enum logic [opcodeW-1:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opAddi  = 5'b01000,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opLbi   = 5'b11000,
        opRtype = 5'b11011
    } opcodeT;

    typedef enum logic [functW-1:0] {
        fnAdd  = 2'b00,
        fnSub  = 2'b01,
        fnXor  = 2'b10,
        fnAndn = 2'b11
    } functT;

    typedef enum logic [1:0] {imm5S, imm5U, imm8S, imm11S} immKindT;

    // Instruction field that names the destination register
    typedef enum logic [1:0] {dstRt, dstRd, dstRs} destSelT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluXor, aluAndn, aluPassB} aluOpT;

    typedef enum logic [1:0] {brNone, brEqz, brNez, brAlways} branchKindT;

    typedef struct packed {
        aluOpT      aluOp;
        logic       aluSrcImm;
        branchKindT branchKind;
        logic       regWrite;
        logic       halt;
        logic       illegal;
    } ctrlT;

endpackage
